/* dcache.f */
hw/dcache_pkg.sv
hw/dcache_store.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_checker.sv
verif/tb_dcache.sv

/* hw/dcache_ctrl.sv */
// miss-handling FSM driving memory requests and store updates
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input  logic              clk,
	input  logic              proc_reset,
	input  proc_req_t         req,
	input  logic              hit,
	input  logic              hit_way,
	input  logic              victim,
	input  logic              victim_dirty,
	input  logic [tag_w-1:0]  victim_tag,
	input  logic [line_w-1:0] victim_data,
	input  logic [line_w-1:0] mem_rdata,
	input  logic              mem_ready,
	output mem_req_t          mem_req,
	output logic              proc_stall,
	output store_op_e         op,
	output logic              way,
	output logic [line_w-1:0] fill_data
);

	cache_state_e state;
	cache_state_e next_state;
	addr_t        a;
	logic         active;
	logic         miss;

	assign a      = req.addr;
	assign active = req.read | req.write;
	assign miss   = active & ~hit;

	// refill data comes straight from memory, op decides when it is taken
	assign fill_data = mem_rdata;

	// ------------------------------------------------------------------------
	// state register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	// ------------------------------------------------------------------------
	// next state and outputs
	// ------------------------------------------------------------------------
	always_comb begin
		next_state = state;
		mem_req    = '0;
		proc_stall = 1'b1;
		op         = op_none;
		way        = victim;

		case (state)
			s_idle: begin
				next_state = s_compare_tag;  // one stall cycle after reset
			end

			s_compare_tag: begin
				proc_stall = miss;
				if (miss) begin
					next_state = victim_dirty ? s_write_back : s_allocate;
				end else if (req.write) begin
					op  = op_write_word;  // hit, word lands at this edge
					way = hit_way;
				end
			end

			s_write_back: begin
				// victim line goes out under its own tag
				mem_req.write = 1'b1;
				mem_req.addr  = {victim_tag, a.index};
				mem_req.wdata = victim_data;
				if (mem_ready) begin
					op         = op_clean;
					next_state = s_allocate;
				end
			end

			s_allocate: begin
				mem_req.read = 1'b1;  // held through the ready cycle
				mem_req.addr = {a.tag, a.index};
				if (mem_ready) begin
					op         = op_fill;
					next_state = s_compare_tag;  // retried there as a hit
				end
			end

			default: begin
				next_state = s_idle;
			end
		endcase
	end

endmodule

/* hw/dcache_lookup.sv */
// tag compare, hit way, read word select and victim line description
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
	input  logic [proc_addr_w-1:0] addr,
	input  line_t                  way0_line,
	input  line_t                  way1_line,
	input  logic                   victim,
	output logic                   hit,
	output logic                   hit_way,
	output logic [word_w-1:0]      rdata,
	output logic                   victim_dirty,
	output logic [tag_w-1:0]       victim_tag,
	output logic [line_w-1:0]      victim_data
);

	addr_t a;
	logic  hit0;
	logic  hit1;
	line_t hit_line;
	line_t victim_line;

	assign a = addr;

	// ------------------------------------------------------------------------
	// tag compare
	// ------------------------------------------------------------------------
	assign hit0 = way0_line.valid && (way0_line.tag == a.tag);
	assign hit1 = way1_line.valid && (way1_line.tag == a.tag);

	assign hit     = hit0 | hit1;
	assign hit_way = hit1;  // a tag lives in one way only

	assign hit_line = hit_way ? way1_line : way0_line;

	always_comb begin
		rdata = '0;
		if (hit) begin
			rdata = hit_line.data[a.offset*word_w +: word_w];
		end
	end

	// victim for the controller
	assign victim_line  = victim ? way1_line : way0_line;
	assign victim_dirty = victim_line.valid & victim_line.dirty;
	assign victim_tag   = victim_line.tag;
	assign victim_data  = victim_line.data;

endmodule

/* hw/dcache_pkg.sv */
// data cache geometry, address fields, line/request structs, state and store-op enums
package dcache_pkg;

	// ------------------------------------------------------------------------
	// geometry
	// ------------------------------------------------------------------------
	localparam int n_sets         = 4;
	localparam int n_ways         = 2;
	localparam int words_per_line = 4;

	localparam int word_w      = 32;
	localparam int line_w      = word_w * words_per_line;  // 128
	localparam int proc_addr_w = 30;                       // word address
	localparam int index_w     = 2;
	localparam int offset_w    = 2;
	localparam int mem_addr_w  = proc_addr_w - offset_w;   // line address
	localparam int tag_w       = mem_addr_w - index_w;

	// processor word address, msb first
	typedef struct packed {
		logic [tag_w-1:0]    tag;
		logic [index_w-1:0]  index;
		logic [offset_w-1:0] offset;
	} addr_t;

	// one stored line, 156 bits
	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic [tag_w-1:0]  tag;
		logic [line_w-1:0] data;
	} line_t;

	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [proc_addr_w-1:0] addr;
		logic [word_w-1:0]      wdata;
	} proc_req_t;

	typedef struct packed {
		logic                  read;
		logic                  write;
		logic [mem_addr_w-1:0] addr;   // line address
		logic [line_w-1:0]     wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		s_idle, s_compare_tag, s_write_back, s_allocate
	} cache_state_e;

	typedef enum logic [1:0] {
		op_none, op_write_word, op_fill, op_clean
	} store_op_e;

endpackage

/* hw/dcache_store.sv */
// tag, data, valid, dirty and victim storage for both ways of the data cache
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  logic [proc_addr_w-1:0] addr,
	input  store_op_e              op,
	input  logic                   way,
	input  logic [word_w-1:0]      wdata,
	input  logic [line_w-1:0]      fill_data,
	output line_t                  way0_line,
	output line_t                  way1_line,
	output logic                   victim
);

	addr_t a;
	line_t lines [n_ways][n_sets];
	logic  victim_q [n_sets];  // way to replace next in each set

	assign a = addr;

	// ------------------------------------------------------------------------
	// read side, addressed set only
	// ------------------------------------------------------------------------
	assign way0_line = lines[0][a.index];
	assign way1_line = lines[1][a.index];
	assign victim    = victim_q[a.index];

	// ------------------------------------------------------------------------
	// update port
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < n_sets; s++) begin
				for (int w = 0; w < n_ways; w++) begin
					lines[w][s] <= '0;  // invalid, clean
				end
				victim_q[s] <= 1'b0;  // way 0 goes first
			end
		end else begin
			case (op)
				op_write_word: begin
					lines[way][a.index].data[a.offset*word_w +: word_w] <= wdata;
					lines[way][a.index].dirty <= 1'b1;
				end
				op_fill: begin
					lines[way][a.index].data  <= fill_data;
					lines[way][a.index].tag   <= a.tag;
					lines[way][a.index].valid <= 1'b1;
					lines[way][a.index].dirty <= 1'b0;
					victim_q[a.index]         <= ~way;  // other way is older now
				end
				op_clean: begin
					lines[way][a.index].dirty <= 1'b0;  // after write-back
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* hw/dcache_top.sv */
// data cache top level, store + lookup + controller
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
	input  logic              clk,
	input  logic              proc_reset,
	input  proc_req_t         proc_req,
	output logic [word_w-1:0] proc_rdata,
	output logic              proc_stall,
	output mem_req_t          mem_req,
	input  logic [line_w-1:0] mem_rdata,
	input  logic              mem_ready
);

	line_t             way0_line;
	line_t             way1_line;
	logic              victim;
	logic              hit;
	logic              hit_way;
	logic              victim_dirty;
	logic [tag_w-1:0]  victim_tag;
	logic [line_w-1:0] victim_data;
	store_op_e         op;
	logic              way;
	logic [line_w-1:0] fill_data;

	dcache_store i_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.addr       (proc_req.addr),
		.op         (op),
		.way        (way),
		.wdata      (proc_req.wdata),
		.fill_data  (fill_data),
		.way0_line  (way0_line),
		.way1_line  (way1_line),
		.victim     (victim)
	);

	dcache_lookup i_lookup (
		.addr         (proc_req.addr),
		.way0_line    (way0_line),
		.way1_line    (way1_line),
		.victim       (victim),
		.hit          (hit),
		.hit_way      (hit_way),
		.rdata        (proc_rdata),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_data  (victim_data)
	);

	dcache_ctrl i_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.req          (proc_req),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim       (victim),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_data  (victim_data),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready),
		.mem_req      (mem_req),
		.proc_stall   (proc_stall),
		.op           (op),
		.way          (way),
		.fill_data    (fill_data)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_dcache -f dcache.f -o sim_dcache \
	&& ./obj_dir/sim_dcache | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verif/dcache_checker.sv */
// checker for the data cache ports covering the reset cycle, read data, hit and write-back flags
`timescale 1ns/1ps

module dcache_checker import dcache_pkg::*; (
	input  logic              clk,
	input  logic              proc_reset,
	input  proc_req_t         proc_req,
	input  logic [word_w-1:0] proc_rdata,
	input  logic              proc_stall,
	input  mem_req_t          mem_req,
	output int                errors,
	output int                completed
);

	localparam int max_patterns = 64;
	localparam int pat_cols     = 6;

	logic [31:0] pat_mem [max_patterns*pat_cols];
	int          n_patterns;
	logic        in_reset = 1'b0;
	logic        stalled  = 1'b0;  // request saw a stall cycle
	logic        saw_wb   = 1'b0;  // request saw a memory write

	initial begin
		errors    = 0;
		completed = 0;
		for (int i = 0; i < max_patterns*pat_cols; i++) begin
			pat_mem[i] = '0;
		end
		$readmemh("verif/dcache_patterns.txt", pat_mem);
		n_patterns = 0;
		while (n_patterns < max_patterns &&
		       (pat_mem[n_patterns*pat_cols] == 32'd1 ||
		        pat_mem[n_patterns*pat_cols] == 32'd2)) begin
			n_patterns++;
		end
	end

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED time %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_completion(input int idx, input logic hit_seen, input logic wb_seen);
		int          base;
		logic [31:0] exp_rdata;
		base = idx * pat_cols;
		if (idx >= n_patterns) begin
			$display("a request completed that is not in the pattern list");
			errors++;
			return;
		end
		exp_rdata = pat_mem[base+3];
		if (proc_req.read && proc_rdata !== exp_rdata) begin
			report_mismatch($sformatf("request %0d read %h, expected %h",
			                idx, proc_rdata, exp_rdata));
		end
		if (hit_seen != pat_mem[base+4][0]) begin
			report_mismatch($sformatf("request %0d hit %0b, expected %0b",
			                idx, hit_seen, pat_mem[base+4][0]));
		end
		if (wb_seen != pat_mem[base+5][0]) begin
			report_mismatch($sformatf("request %0d write-back %0b, expected %0b",
			                idx, wb_seen, pat_mem[base+5][0]));
		end
	endtask

	// ------------------------------------------------------------------------
	// every cycle sampled at the rising edge
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			in_reset <= 1'b1;
			stalled  <= 1'b0;
			saw_wb   <= 1'b0;
		end else begin
			in_reset <= 1'b0;
			if (in_reset) begin  // first cycle out of reset
				if (!proc_stall) begin
					report_mismatch("stall low in the first cycle after reset");
				end
				if (mem_req.read || mem_req.write) begin
					report_mismatch("memory request in the first cycle after reset");
				end
			end
			if (proc_req.read || proc_req.write) begin
				if (proc_stall) begin
					stalled <= 1'b1;
					saw_wb  <= saw_wb | mem_req.write;
				end else begin
					check_completion(completed, ~stalled, saw_wb | mem_req.write);
					completed++;
					stalled <= 1'b0;
					saw_wb  <= 1'b0;
				end
			end
		end
	end

endmodule

/* verif/dcache_patterns.txt */
// op (1 read, 2 write), word address, write data, expected read data,
// expected hit (no stall), expected memory write-back during the request
1 00000010 00000000 5a5a0010 0 0
1 00000011 00000000 5a5a0011 1 0
1 00000013 00000000 5a5a0013 1 0
2 00000012 cafe0012 00000000 1 0
1 00000012 00000000 cafe0012 1 0
1 00000020 00000000 5a5a0020 0 0
1 00000010 00000000 5a5a0010 1 0
1 00000023 00000000 5a5a0023 1 0
1 00000030 00000000 5a5a0030 0 1
1 00000020 00000000 5a5a0020 1 0
1 00000010 00000000 5a5a0010 0 0
1 00000012 00000000 cafe0012 1 0
1 00000033 00000000 5a5a0033 1 0
1 00000020 00000000 5a5a0020 0 0
1 00000030 00000000 5a5a0030 0 0
2 00000015 11110015 00000000 0 0
2 00000026 22220026 00000000 0 0
1 00000015 00000000 11110015 1 0
1 00000026 00000000 22220026 1 0
1 00000034 00000000 5a5a0034 0 1
1 00000014 00000000 5a5a0014 0 1
1 00000015 00000000 11110015 1 0
1 00000024 00000000 5a5a0024 0 0
1 00000026 00000000 22220026 1 0
1 0000001b 00000000 5a5a001b 0 0
2 0000001b 3333001b 00000000 1 0
2 00000018 44440018 00000000 1 0
1 0000001b 00000000 3333001b 1 0
1 00000028 00000000 5a5a0028 0 0
1 00000038 00000000 5a5a0038 0 1
1 00000018 00000000 44440018 0 0
1 0000001b 00000000 3333001b 1 0
1 3ffffffc 00000000 65a5fffc 0 0
2 3ffffffe deadbeef 00000000 1 0
1 0000000c 00000000 5a5a000c 0 0
1 0000004c 00000000 5a5a004c 0 1
1 3ffffffe 00000000 deadbeef 0 0
1 0000004f 00000000 5a5a004f 1 0

/* verif/tb_dcache.sv */
// data cache testbench top with clock, reset, slow-memory model, pattern stimulus and timeout
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

	localparam int max_patterns       = 64;
	localparam int pat_cols           = 6;   // op, addr, wdata, rdata, hit, write-back
	localparam int cycles_per_pattern = 20;

	logic              clk        = 1'b0;
	logic              proc_reset = 1'b1;
	proc_req_t         proc_req   = '0;
	logic [line_w-1:0] mem_rdata  = '0;
	logic              mem_ready  = 1'b0;
	logic [word_w-1:0] proc_rdata;
	logic              proc_stall;
	mem_req_t          mem_req;

	logic [31:0] pat_mem [max_patterns*pat_cols];
	int          n_patterns;
	int          timeout_limit = 0;
	int          cycle_count   = 0;
	int          errors;
	int          completed;

	// slow memory, only lines that were written back are kept
	logic [line_w-1:0] backing [logic [mem_addr_w-1:0]];
	logic              mem_pending = 1'b0;
	int                mem_wait    = 0;

	dcache_top i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	dcache_checker i_checker (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.errors     (errors),
		.completed  (completed)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	function automatic int count_patterns();
		int n = 0;
		while (n < max_patterns &&
		       (pat_mem[n*pat_cols] == 32'd1 || pat_mem[n*pat_cols] == 32'd2)) begin
			n++;
		end
		return n;
	endfunction

	function automatic proc_req_t request_from_pattern(input int idx);
		proc_req_t r;
		r       = '0;
		r.read  = (pat_mem[idx*pat_cols] == 32'd1);
		r.write = (pat_mem[idx*pat_cols] == 32'd2);
		r.addr  = pat_mem[idx*pat_cols+1][proc_addr_w-1:0];
		r.wdata = pat_mem[idx*pat_cols+2];
		return r;
	endfunction

	// initial contents: each word holds its own word address ^ 0x5a5a0000
	function automatic logic [line_w-1:0] line_from_memory(input logic [mem_addr_w-1:0] la);
		logic [line_w-1:0] data;
		if (backing.exists(la)) begin
			return backing[la];
		end
		for (int k = 0; k < words_per_line; k++) begin
			data[k*word_w +: word_w] = {2'b00, la, 2'(k)} ^ 32'h5a5a0000;
		end
		return data;
	endfunction

	// ------------------------------------------------------------------------
	// slow memory, 1 to 4 cycles before a one-cycle ready
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			mem_ready   <= 1'b0;
			mem_pending <= 1'b0;
			mem_wait    <= 0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;
			if (mem_req.write) begin
				backing[mem_req.addr] = mem_req.wdata;  // taken in the ready cycle
			end
		end else if (mem_req.read || mem_req.write) begin
			if (!mem_pending) begin
				mem_pending <= 1'b1;
				mem_wait    <= 1 + int'($urandom % 4);
			end else if (mem_wait > 1) begin
				mem_wait <= mem_wait - 1;
			end else begin
				mem_pending <= 1'b0;
				mem_ready   <= 1'b1;
				if (mem_req.read) begin
					mem_rdata <= line_from_memory(mem_req.addr);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("timeout: requests still pending after %0d cycles", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(3947));
		for (int i = 0; i < max_patterns*pat_cols; i++) begin
			pat_mem[i] = '0;
		end
		$readmemh("verif/dcache_patterns.txt", pat_mem);
		n_patterns    = count_patterns();
		timeout_limit = n_patterns * cycles_per_pattern;
		if (n_patterns == 0) begin
			$display("no requests found in verif/dcache_patterns.txt");
		end

		repeat (5) @(posedge clk);
		proc_reset <= 1'b0;
		@(posedge clk);

		for (int i = 0; i < n_patterns; i++) begin
			proc_req <= request_from_pattern(i);
			@(posedge clk);
			while (proc_stall) begin
				@(posedge clk);  // held until the cache lets go
			end
		end
		proc_req <= '0;
		repeat (2) @(posedge clk);

		if (completed != n_patterns) begin
			$display("only %0d of %0d requests completed", completed, n_patterns);
		end
		$display("summary: %0d errors, %0d of %0d requests completed",
		         errors, completed, n_patterns);
		if (errors == 0 && completed == n_patterns && n_patterns > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
